// ==== dv/csr_unit_tb.sv ====
`include "csr_cfg.svh"

module csr_unit_tb;

  import csr_pkg::*;

  localparam int N_RANDOM = 300;
  localparam int N_REQ    = N_RANDOM + 40;
  localparam int TIMEOUT  = N_REQ * 40 + 2000;
  localparam int RETIRE_K = 7;

  logic          clk;
  logic          rst;
  logic          req_valid;
  logic          req_ready;
  csr_req_t      req;
  csr_trap_t     trap;
  logic          rsp_valid;
  logic          rsp_ready;
  csr_rsp_t      rsp;
  csr_redirect_t redirect;

  integer        seed = 63225;
  logic [31:0]   model_mem [0:4095];
  csr_rsp_t      exp_q[$];
  logic [31:0]   redir_q[$];
  logic [31:0]   last_data;
  logic [4:0]    tag;

  csr_unit uut (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .trap      (trap),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .redirect  (redirect)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      abort($sformatf("error at time %0t: %s is %08h, expected %08h",
                      $time, what, actual, expected));
    end
  endtask

  // Software-writable bits per address
  function automatic logic [31:0] write_mask(input logic [11:0] addr);
    case (addr)
      `CSR_ADDR_MSTATUS: return `CSR_MSTATUS_WMASK;
      `CSR_ADDR_MISA:    return `CSR_MISA_WMASK;
      `CSR_ADDR_MIE:     return `CSR_MIE_WMASK;
      `CSR_ADDR_MIP:     return `CSR_MIP_WMASK;
      `CSR_ADDR_MEDELEG, `CSR_ADDR_MIDELEG, `CSR_ADDR_MTVEC, `CSR_ADDR_MCOUNTEREN,
      `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL:
        return 32'hFFFF_FFFF;
      default:           return 32'h0;
    endcase
  endfunction

  // Reference for the read-modify-write
  function automatic logic [31:0] next_value(input csr_op_t op, input logic [31:0] old,
                                             input logic [31:0] operand);
    case (op)
      CSR_RW:  return operand;
      CSR_RS:  return old | operand;
      CSR_RC:  return old & ~operand;
      default: return old;
    endcase
  endfunction

  function automatic logic [11:0] pick_addr(input logic [2:0] sel);
    case (sel)
      3'd0:    return `CSR_ADDR_MSCRATCH;
      3'd1:    return `CSR_ADDR_MTVEC;
      3'd2:    return `CSR_ADDR_MEPC;
      3'd3:    return `CSR_ADDR_MCAUSE;
      3'd4:    return `CSR_ADDR_MTVAL;
      3'd5:    return `CSR_ADDR_MEDELEG;
      3'd6:    return `CSR_ADDR_MIDELEG;
      default: return `CSR_ADDR_MCOUNTEREN;
    endcase
  endfunction

  // Starts and ends at a falling edge
  task automatic send_req(input csr_op_t op, input logic [11:0] addr,
                          input logic [31:0] operand);
    logic [31:0] old;
    logic [31:0] mask;
    req_valid = 1'b1;
    req       = '{op: op, addr: addr, operand: operand, rd: tag};
    do @(posedge clk); while (!req_ready);
    old  = model_mem[addr];
    mask = write_mask(addr);
    exp_q.push_back('{data: old, rd: tag});
    model_mem[addr] = (old & ~mask) | (next_value(op, old, operand) & mask);
    tag = tag + 5'd1;
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic raise_exception(input logic [3:0] cause, input logic [31:0] epc,
                                 input logic [31:0] tval);
    logic [31:0] base;
    drain();
    trap.exception = 1'b1;
    trap.ecause    = cause;
    trap.epc       = epc;
    trap.etval     = tval;
    model_mem[`CSR_ADDR_MEPC]       = epc;
    model_mem[`CSR_ADDR_MCAUSE]     = 32'(cause);
    model_mem[`CSR_ADDR_MTVAL]      = tval;
    model_mem[`CSR_ADDR_MSTATUS][7] = model_mem[`CSR_ADDR_MSTATUS][3];
    model_mem[`CSR_ADDR_MSTATUS][3] = 1'b0;
    base = model_mem[`CSR_ADDR_MTVEC] & 32'hFFFF_FFFC;
    if (model_mem[`CSR_ADDR_MTVEC][1:0] == 2'b01) begin
      redir_q.push_back(base + (32'(cause) << 2));
    end else begin
      redir_q.push_back(base);
    end
    @(negedge clk);
    trap = '0;
    // Redirect is up between the second and third edge after the pulse
    @(negedge clk);
    compare(32'(redirect.valid), 32'd1, "redirect valid");
    repeat (2) @(negedge clk);
  endtask

  task automatic return_from_trap();
    drain();
    trap.mret = 1'b1;
    // MPIE is left clear after the return
    model_mem[`CSR_ADDR_MSTATUS][3] = model_mem[`CSR_ADDR_MSTATUS][7];
    model_mem[`CSR_ADDR_MSTATUS][7] = 1'b0;
    redir_q.push_back(model_mem[`CSR_ADDR_MEPC]);
    @(negedge clk);
    trap = '0;
    @(negedge clk);
    compare(32'(redirect.valid), 32'd1, "redirect valid");
    repeat (2) @(negedge clk);
  endtask

  task automatic retire_burst(input int count);
    trap.retire = 1'b1;
    model_mem[`CSR_ADDR_MINSTRET] = model_mem[`CSR_ADDR_MINSTRET] + 32'(count);
    repeat (count) @(negedge clk);
    trap.retire = 1'b0;
  endtask

  task automatic read_trap_state();
    send_req(CSR_RD, `CSR_ADDR_MEPC, 32'h0);
    send_req(CSR_RD, `CSR_ADDR_MCAUSE, 32'h0);
    send_req(CSR_RD, `CSR_ADDR_MTVAL, 32'h0);
    send_req(CSR_RD, `CSR_ADDR_MSTATUS, 32'h0);
  endtask

  // Random back-pressure on the response side
  initial begin
    logic [31:0] r;
    rsp_ready = 1'b0;
    forever begin
      @(posedge clk);
      r = $random(seed);
      @(negedge clk);
      rsp_ready = r[1:0] != 2'b00;
    end
  end

  always @(posedge clk) begin
    if (rst && rsp_valid && rsp_ready) begin
      if (exp_q.size() == 0) begin
        abort("A response arrived with no request outstanding");
      end else begin
        compare(rsp.data, exp_q[0].data, "response data");
        compare(32'(rsp.rd), 32'(exp_q[0].rd), "response tag");
        last_data = rsp.data;
        void'(exp_q.pop_front());
      end
    end
    if (rst && redirect.valid) begin
      if (redir_q.size() == 0) begin
        abort("A redirect arrived with no trap or mret before it");
      end else begin
        compare(redirect.target, redir_q[0], "redirect target");
        void'(redir_q.pop_front());
      end
    end
  end

  initial begin
    #(TIMEOUT);
    abort("Timeout: the simulation did not finish within the time limit");
  end

  initial begin
    logic [31:0] r;
    logic [31:0] operand;
    logic [31:0] first;
    logic [12:0] a;
    rst       = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    trap      = '0;
    tag       = '0;
    last_data = '0;
    for (a = 13'd0; a < 13'd4096; a = a + 13'd1) begin
      model_mem[a[11:0]] = 32'h0;
    end
    // RV32I with MXL = 1 and the I bit
    model_mem[`CSR_ADDR_MISA] = 32'h4000_0100;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    @(negedge clk);

    for (int i = 0; i < N_RANDOM; i++) begin
      r       = $random(seed);
      operand = $random(seed);
      send_req(csr_op_t'(r[1:0]), pick_addr(r[4:2]), operand);
      if (r[7:6] == 2'b00) @(negedge clk);
    end

    // Sparse registers, then an unimplemented address
    send_req(CSR_RW, `CSR_ADDR_MSTATUS, 32'hFFFF_FFFF);
    send_req(CSR_RD, `CSR_ADDR_MSTATUS, 32'h0);
    send_req(CSR_RW, `CSR_ADDR_MISA, 32'hFFFF_FFFF);
    send_req(CSR_RD, `CSR_ADDR_MISA, 32'h0);
    send_req(CSR_RW, `CSR_ADDR_MIE, 32'hFFFF_FFFF);
    send_req(CSR_RD, `CSR_ADDR_MIE, 32'h0);
    send_req(CSR_RW, `CSR_ADDR_MIP, 32'hFFFF_FFFF);
    send_req(CSR_RD, `CSR_ADDR_MIP, 32'h0);
    send_req(CSR_RW, 12'h7C0, 32'hFFFF_FFFF);
    send_req(CSR_RD, 12'h7C0, 32'h0);

    // Direct mode trap, then vectored mode trap and return
    send_req(CSR_RW, `CSR_ADDR_MTVEC, 32'h0000_1000);
    send_req(CSR_RS, `CSR_ADDR_MSTATUS, 32'h0000_0008);
    raise_exception(4'd5, 32'h0000_0080, 32'hDEAD_BEEF);
    read_trap_state();
    send_req(CSR_RW, `CSR_ADDR_MTVEC, 32'h0000_2001);
    send_req(CSR_RS, `CSR_ADDR_MSTATUS, 32'h0000_0008);
    raise_exception(4'd11, 32'h0000_0400, 32'h0000_1234);
    read_trap_state();
    return_from_trap();
    send_req(CSR_RD, `CSR_ADDR_MSTATUS, 32'h0);

    // Retire count between two reads
    send_req(CSR_RD, `CSR_ADDR_MINSTRET, 32'h0);
    drain();
    first = last_data;
    retire_burst(RETIRE_K);
    send_req(CSR_RD, `CSR_ADDR_MINSTRET, 32'h0);
    drain();
    compare(last_data - first, RETIRE_K, "minstret delta");

    repeat (5) @(negedge clk);
    if (exp_q.size() == 0 && redir_q.size() == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      abort("Responses or redirects were still outstanding at the end of the run");
    end
  end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_request.sv
verilog/csr.sv
verilog/csr_response.sv
verilog/csr_unit.sv
dv/csr_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f files.f --top-module csr_unit_tb \
    -o csr_unit_sim; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/csr_unit_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
fi

if grep -q "^Test passed$" <<< "$sim_out"; then
  exit 0
fi
exit 1

// ==== verilog/csr.sv ====
`include "csr_cfg.svh"

module csr (
  input  logic                 clk,
  input  logic                 rst,
  input  csr_pkg::csr_in_type  csr_in,
  output csr_pkg::csr_out_type csr_out
);

  import csr_pkg::*;

  csr_machine_reg_type  machine_reg;
  logic                 exception_q;
  logic                 mret_q;
  logic [`CSR_XLEN-1:0] rdata;

  // Sparse registers only ever hold their implemented bits
  always_comb begin
    case (csr_in.craddr)
      `CSR_ADDR_MSTATUS:    rdata = machine_reg.mstatus;
      `CSR_ADDR_MISA:       rdata = machine_reg.misa;
      `CSR_ADDR_MEDELEG:    rdata = machine_reg.medeleg;
      `CSR_ADDR_MIDELEG:    rdata = machine_reg.mideleg;
      `CSR_ADDR_MIE:        rdata = machine_reg.mie;
      `CSR_ADDR_MTVEC:      rdata = machine_reg.mtvec;
      `CSR_ADDR_MCOUNTEREN: rdata = machine_reg.mcounteren;
      `CSR_ADDR_MSCRATCH:   rdata = machine_reg.mscratch;
      `CSR_ADDR_MEPC:       rdata = machine_reg.mepc;
      `CSR_ADDR_MCAUSE:     rdata = machine_reg.mcause;
      `CSR_ADDR_MTVAL:      rdata = machine_reg.mtval;
      `CSR_ADDR_MIP:        rdata = machine_reg.mip;
      `CSR_ADDR_MCYCLE:     rdata = machine_reg.mcycle[31:0];
      `CSR_ADDR_MCYCLEH:    rdata = machine_reg.mcycle[63:32];
      `CSR_ADDR_MINSTRET:   rdata = machine_reg.minstret[31:0];
      `CSR_ADDR_MINSTRETH:  rdata = machine_reg.minstret[63:32];
      default:              rdata = '0;
    endcase
  end

  always_comb begin
    csr_out.cdata     = csr_in.crden ? rdata : '0;
    csr_out.exception = exception_q;
    csr_out.mret      = mret_q;
    csr_out.mepc      = machine_reg.mepc;
    // Vectored mode adds 4 * cause to the base
    if (machine_reg.mtvec[1:0] == 2'b01) begin
      csr_out.mtvec = {machine_reg.mtvec[`CSR_XLEN-1:2] +
                       (`CSR_XLEN-2)'(machine_reg.mcause[3:0]), 2'b00};
    end else begin
      csr_out.mtvec = {machine_reg.mtvec[`CSR_XLEN-1:2], 2'b00};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      machine_reg <= init_csr_machine_reg;
      exception_q <= 1'b0;
      mret_q      <= 1'b0;
    end else begin
      if (csr_in.cwren) begin
        case (csr_in.cwaddr)
          `CSR_ADDR_MSTATUS:
            machine_reg.mstatus <= csr_in.cdata & `CSR_MSTATUS_WMASK;
          `CSR_ADDR_MISA:
            machine_reg.misa <= csr_in.cdata & `CSR_MISA_WMASK;
          `CSR_ADDR_MEDELEG:    machine_reg.medeleg <= csr_in.cdata;
          `CSR_ADDR_MIDELEG:    machine_reg.mideleg <= csr_in.cdata;
          `CSR_ADDR_MIE:
            machine_reg.mie <= csr_in.cdata & `CSR_MIE_WMASK;
          `CSR_ADDR_MTVEC:      machine_reg.mtvec <= csr_in.cdata;
          `CSR_ADDR_MCOUNTEREN: machine_reg.mcounteren <= csr_in.cdata;
          `CSR_ADDR_MSCRATCH:   machine_reg.mscratch <= csr_in.cdata;
          `CSR_ADDR_MEPC:       machine_reg.mepc <= csr_in.cdata;
          `CSR_ADDR_MCAUSE:     machine_reg.mcause <= csr_in.cdata;
          `CSR_ADDR_MTVAL:      machine_reg.mtval <= csr_in.cdata;
          `CSR_ADDR_MIP:
            machine_reg.mip <= csr_in.cdata & `CSR_MIP_WMASK;
          `CSR_ADDR_MINSTRET:   machine_reg.minstret[31:0] <= csr_in.cdata;
          `CSR_ADDR_MINSTRETH:  machine_reg.minstret[63:32] <= csr_in.cdata;
          // mcycle ticks every cycle, so a write to it never lands
          default: ;
        endcase
      end

      machine_reg.mcycle <= machine_reg.mcycle + 64'd1;
      if (csr_in.retire) begin
        machine_reg.minstret <= machine_reg.minstret + 64'd1;
      end

      // Trap entry, MIE saved to MPIE
      if (csr_in.exception) begin
        machine_reg.mstatus[7] <= machine_reg.mstatus[3];
        machine_reg.mstatus[3] <= 1'b0;
        machine_reg.mepc       <= csr_in.epc;
        machine_reg.mtval      <= csr_in.etval;
        machine_reg.mcause     <= {{(`CSR_XLEN-4){1'b0}}, csr_in.ecause};
      end

      // Trap return
      if (csr_in.mret) begin
        machine_reg.mstatus[3] <= machine_reg.mstatus[7];
        machine_reg.mstatus[7] <= 1'b0;
      end

      exception_q <= csr_in.exception;
      mret_q      <= csr_in.mret;
    end
  end

  a_trap_exclusive: assert property (@(posedge clk) disable iff (!rst)
    !(csr_in.exception && csr_in.mret));

endmodule

// ==== verilog/csr_cfg.svh ====
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define CSR_XLEN 32

// Machine information and trap setup
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MEDELEG    12'h302
`define CSR_ADDR_MIDELEG    12'h303
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MCOUNTEREN 12'h306

// Trap handling
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343
`define CSR_ADDR_MIP        12'h344

// Counters, low and high halves
`define CSR_ADDR_MCYCLE     12'hB00
`define CSR_ADDR_MINSTRET   12'hB02
`define CSR_ADDR_MCYCLEH    12'hB80
`define CSR_ADDR_MINSTRETH  12'hB82

// Implemented bits of the sparse registers
`define CSR_MSTATUS_WMASK   32'h807F_F9BB
`define CSR_MISA_WMASK      32'hC3FF_FFFF
`define CSR_MIE_WMASK       32'h0000_0BBB
`define CSR_MIP_WMASK       32'h0000_0BBB

`endif

// ==== verilog/csr_pkg.sv ====
`include "csr_cfg.svh"

package csr_pkg;

  typedef enum logic [1:0] {
    CSR_RD = 2'b00,
    CSR_RW = 2'b01,
    CSR_RS = 2'b10,
    CSR_RC = 2'b11
  } csr_op_t;

  typedef struct packed {
    csr_op_t              op;
    logic [11:0]          addr;
    logic [`CSR_XLEN-1:0] operand;
    logic [4:0]           rd;
  } csr_req_t;

  typedef struct packed {
    logic [`CSR_XLEN-1:0] data;
    logic [4:0]           rd;
  } csr_rsp_t;

  // Single-cycle pulses from the pipeline
  typedef struct packed {
    logic                 exception;
    logic [3:0]           ecause;
    logic [`CSR_XLEN-1:0] epc;
    logic [`CSR_XLEN-1:0] etval;
    logic                 mret;
    logic                 retire;
  } csr_trap_t;

  typedef struct packed {
    logic                 valid;
    logic [`CSR_XLEN-1:0] target;
  } csr_redirect_t;

  typedef struct packed {
    logic                 crden;
    logic [11:0]          craddr;
    logic                 cwren;
    logic [11:0]          cwaddr;
    logic [`CSR_XLEN-1:0] cdata;
    logic                 exception;
    logic [3:0]           ecause;
    logic [`CSR_XLEN-1:0] epc;
    logic [`CSR_XLEN-1:0] etval;
    logic                 mret;
    logic                 retire;
  } csr_in_type;

  typedef struct packed {
    logic [`CSR_XLEN-1:0] cdata;
    logic                 exception;
    logic                 mret;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mtvec;
  } csr_out_type;

  typedef struct packed {
    logic [`CSR_XLEN-1:0] mstatus;
    logic [`CSR_XLEN-1:0] misa;
    logic [`CSR_XLEN-1:0] medeleg;
    logic [`CSR_XLEN-1:0] mideleg;
    logic [`CSR_XLEN-1:0] mie;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mcounteren;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mtval;
    logic [`CSR_XLEN-1:0] mip;
    logic [63:0]          mcycle;
    logic [63:0]          minstret;
  } csr_machine_reg_type;

  // misa: MXL = 1 (32 bit), I extension
  localparam csr_machine_reg_type init_csr_machine_reg = '{
    misa:    32'h4000_0100,
    default: '0
  };

endpackage

// ==== verilog/csr_request.sv ====
`include "csr_cfg.svh"

module csr_request (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_valid,
  input  csr_pkg::csr_req_t    req,
  output logic                 req_ready,
  input  logic [`CSR_XLEN-1:0] rd_data,
  output csr_pkg::csr_in_type  rf_ctrl,
  input  logic                 slot_free,
  output logic                 pass_valid,
  output csr_pkg::csr_rsp_t    pass
);

  import csr_pkg::*;

  logic                 enable;
  logic                 accept;
  logic                 has_write;
  logic [`CSR_XLEN-1:0] wdata;

  // Ready stays low until the first cycle out of reset
  always_ff @(posedge clk) begin
    if (!rst) begin
      enable <= 1'b0;
    end else begin
      enable <= 1'b1;
    end
  end

  assign req_ready = enable & slot_free;
  assign accept    = req_valid & req_ready;

  // Read-modify-write on the old value
  always_comb begin
    case (req.op)
      CSR_RW: begin
        wdata     = req.operand;
        has_write = 1'b1;
      end
      CSR_RS: begin
        wdata     = rd_data | req.operand;
        has_write = |req.operand;
      end
      CSR_RC: begin
        wdata     = rd_data & ~req.operand;
        has_write = |req.operand;
      end
      default: begin
        wdata     = rd_data;
        has_write = 1'b0;
      end
    endcase
  end

  // Trap fields are merged in at the top
  always_comb begin
    rf_ctrl        = '0;
    rf_ctrl.crden  = req_valid;
    rf_ctrl.craddr = req.addr;
    rf_ctrl.cwren  = accept & has_write;
    rf_ctrl.cwaddr = req.addr;
    rf_ctrl.cdata  = wdata;
  end

  assign pass_valid = accept;
  assign pass       = '{data: rd_data, rd: req.rd};

  a_req_stable: assert property (@(posedge clk) disable iff (!rst)
    req_valid && !req_ready |=> $stable(req));

endmodule

// ==== verilog/csr_response.sv ====
module csr_response (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   pass_valid,
  input  csr_pkg::csr_rsp_t      pass,
  output logic                   slot_free,
  output logic                   rsp_valid,
  input  logic                   rsp_ready,
  output csr_pkg::csr_rsp_t      rsp,
  input  csr_pkg::csr_out_type   csr_status,
  output csr_pkg::csr_redirect_t redirect
);

  // Room for a new entry when empty or draining this cycle
  assign slot_free = !rsp_valid || rsp_ready;

  always_ff @(posedge clk) begin
    if (!rst) begin
      rsp_valid      <= 1'b0;
      redirect.valid <= 1'b0;
    end else begin
      if (pass_valid) begin
        rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
      end
      // One cycle after the flag leaves the register file
      redirect.valid <= csr_status.exception | csr_status.mret;
    end
  end

  always_ff @(posedge clk) begin
    if (pass_valid) begin
      rsp <= pass;
    end
    if (csr_status.exception) begin
      redirect.target <= csr_status.mtvec;
    end else begin
      redirect.target <= csr_status.mepc;
    end
  end

  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

// ==== verilog/csr_unit.sv ====
module csr_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req_valid,
  input  csr_pkg::csr_req_t      req,
  output logic                   req_ready,
  input  csr_pkg::csr_trap_t     trap,
  output logic                   rsp_valid,
  input  logic                   rsp_ready,
  output csr_pkg::csr_rsp_t      rsp,
  output csr_pkg::csr_redirect_t redirect
);

  import csr_pkg::*;

  csr_in_type  rf_ctrl;
  csr_in_type  csr_in;
  csr_out_type csr_out;
  csr_rsp_t    pass;
  logic        pass_valid;
  logic        slot_free;

  // Software access from the request side, events straight from the pipeline
  assign csr_in = '{
    crden:     rf_ctrl.crden,
    craddr:    rf_ctrl.craddr,
    cwren:     rf_ctrl.cwren,
    cwaddr:    rf_ctrl.cwaddr,
    cdata:     rf_ctrl.cdata,
    exception: trap.exception,
    ecause:    trap.ecause,
    epc:       trap.epc,
    etval:     trap.etval,
    mret:      trap.mret,
    retire:    trap.retire
  };

  csr_request u_request (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .rd_data    (csr_out.cdata),
    .rf_ctrl    (rf_ctrl),
    .slot_free  (slot_free),
    .pass_valid (pass_valid),
    .pass       (pass)
  );

  csr u_csr (
    .clk     (clk),
    .rst     (rst),
    .csr_in  (csr_in),
    .csr_out (csr_out)
  );

  csr_response u_response (
    .clk        (clk),
    .rst        (rst),
    .pass_valid (pass_valid),
    .pass       (pass),
    .slot_free  (slot_free),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp),
    .csr_status (csr_out),
    .redirect   (redirect)
  );

endmodule
